// File: list.f
+incdir+common
common/csi_pkg.sv
common/csi_payload_if.sv
payload/csi_crc16.sv
payload/csi_payload_checker.sv
src/csi_packet_decoder.sv
src/csi_rx_top.sv
tb/csi_rx_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log && \
  verilator --binary --timing -f list.f --top-module csi_rx_tb -o csi_rx_sim > build.log 2>&1 && \
  ./obj_dir/csi_rx_sim > sim.log 2>&1 || \
  echo "build or simulation returned an error, see build.log and sim.log"
grep -q "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb/csi_rx_tb.sv
// Self-checking testbench for csi_rx_top; needs a simulator with timing support, stimulus is built in
`timescale 1ns/10ps
`include "csi_defs.svh"

module csi_rx_tb;

  // One table row describes a whole packet and the idle cycles in front of it
  typedef struct packed {
    logic [7:0]  dt;
    logic [7:0]  vc;
    logic [15:0] wc;
    logic        corrupt;
    logic [3:0]  gap;
  } row_t;

  // Observed and expected events carry the cycle in which they appear
  typedef struct packed {
    int                  cyc;
    csi_pkg::csi_header_t hdr;
    logic                is_long;
    logic                err;
  } hdr_ev_t;

  typedef struct packed {
    int                 cyc;
    csi_pkg::csi_word_u word;
  } pl_ev_t;

  typedef struct packed {
    int   cyc;
    logic err;
  } crc_ev_t;

  localparam int NROWS = 12;

  // Rows mix short, error, long, zero-length and corrupt packets, back to back and with gaps
  row_t rows [0:NROWS-1] = '{
    '{8'h01, 8'h00, 16'h0000, 1'b0, 4'd0},
    '{8'h0F, 8'h07, 16'h1234, 1'b0, 4'd0},
    '{8'h00, 8'h02, 16'h0010, 1'b0, 4'd1},
    '{8'h2A, 8'h01, 16'h0010, 1'b0, 4'd0},
    '{8'h2B, 8'h05, 16'h0008, 1'b1, 4'd0},
    '{8'h12, 8'h03, 16'h0000, 1'b0, 4'd2},
    '{8'h1E, 8'h00, 16'h0006, 1'b0, 4'd0},
    '{8'h08, 8'h02, 16'h00FF, 1'b0, 4'd0},
    '{8'h24, 8'h02, 16'h0014, 1'b1, 4'd3},
    '{8'h10, 8'h01, 16'h0000, 1'b1, 4'd0},
    '{8'hFF, 8'h0C, 16'h0004, 1'b0, 4'd0},
    '{8'h05, 8'h03, 16'h0003, 1'b0, 4'd1}
  };

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] packet_data;
  logic        packet_req;
  logic [7:0]  packet_type;
  logic [7:0]  virtual_channel;
  logic [15:0] word_count;
  logic        is_long_packet;
  logic        decode_error;
  logic        packet_ack;
  logic [31:0] payload_data;
  logic        payload_strobe;
  logic        crc_strobe;
  logic        crc_error;

  int          cyc = 0;
  logic [31:0] lfsr_state;

  hdr_ev_t want_hdr_q[$];
  hdr_ev_t got_hdr_q[$];
  pl_ev_t  want_pl_q[$];
  pl_ev_t  got_pl_q[$];
  crc_ev_t want_crc_q[$];
  crc_ev_t got_crc_q[$];

  csi_rx_top csi_rx_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .packet_data     (packet_data),
    .packet_req      (packet_req),
    .packet_type     (packet_type),
    .virtual_channel (virtual_channel),
    .word_count      (word_count),
    .is_long_packet  (is_long_packet),
    .decode_error    (decode_error),
    .packet_ack      (packet_ack),
    .payload_data    (payload_data),
    .payload_strobe  (payload_strobe),
    .crc_strobe      (crc_strobe),
    .crc_error       (crc_error)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // The driver reads the cycle count 2 ns after each edge and the monitor at the falling edge
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Outputs are sampled half a cycle after they change, so they are stable here
  always @(negedge clk) begin : monitor
    hdr_ev_t he;
    pl_ev_t  pe;
    crc_ev_t ce;
    if (rst_n) begin
      if (packet_ack) begin
        he.cyc = cyc;
        he.hdr.data_type = packet_type;
        he.hdr.vc_byte = virtual_channel;
        he.hdr.word_count = word_count;
        he.is_long = is_long_packet;
        he.err = decode_error;
        got_hdr_q.push_back(he);
      end
      if (payload_strobe) begin
        pe.cyc = cyc;
        pe.word = payload_data;
        got_pl_q.push_back(pe);
      end
      if (crc_strobe) begin
        ce.cyc = cyc;
        ce.err = crc_error;
        got_crc_q.push_back(ce);
      end
    end
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // The LFSR steps once per bit and the bits are gathered MSB first
  task automatic take_random_bits(input int n, output logic [31:0] value);
    value = 32'h0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // Reflected CRC one byte at a time with the byte XORed into the low end first
  function automatic logic [15:0] crc_update_byte(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] r;
    r = crc ^ {8'h00, data};
    for (int i = 0; i < 8; i++) begin
      if (r[0]) begin
        r = (r >> 1) ^ `CSI_CRC_POLY;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  function automatic logic long_is_valid(input row_t row);
    return (row.dt >= `CSI_LONG_MIN_DT) && (row.wc[1:0] == 2'b00);
  endfunction

  // Counts the words and idle gaps the table puts on the bus to size the watchdog
  function automatic int count_table_words();
    int words;
    words = 0;
    for (int r = 0; r < NROWS; r++) begin
      words = words + 1 + int'(rows[r].gap);
      if (long_is_valid(rows[r])) begin
        words = words + int'(rows[r].wc[15:2]) + 1;
      end
    end
    return words;
  endfunction

  task automatic value_fail(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic drive_word(input csi_pkg::csi_word_u w, output int drive_cyc);
    @(posedge clk);
    #2;
    packet_data = w;
    packet_req = 1'b1;
    drive_cyc = cyc;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #2;
    packet_req = 1'b0;
  endtask

  task automatic check_idle_outputs();
    if (packet_ack !== 1'b0 || payload_strobe !== 1'b0 ||
        crc_strobe !== 1'b0 || crc_error !== 1'b0) begin
      value_fail("a strobe or crc_error is not low after reset");
    end
    if (packet_type !== 8'h00 || virtual_channel !== 8'h00 || word_count !== 16'h0000 ||
        is_long_packet !== 1'b0 || decode_error !== 1'b0) begin
      value_fail("header fields are not cleared by reset");
    end
  endtask

  // Drives one row and records what the DUT must answer and when
  task automatic apply_row(input row_t row);
    csi_pkg::csi_word_u hw;
    csi_pkg::csi_word_u pw;
    logic [31:0]        rnd;
    logic [15:0]        crc;
    logic [15:0]        ck;
    hdr_ev_t            he;
    pl_ev_t             pe;
    crc_ev_t            ce;
    int                 c;
    repeat (row.gap) drive_idle();
    hw.hdr.data_type = row.dt;
    hw.hdr.vc_byte = row.vc;
    hw.hdr.word_count = row.wc;
    drive_word(hw, c);
    he.cyc = c + 2;
    he.hdr.data_type = row.dt;
    he.hdr.vc_byte = row.vc & `CSI_VC_MASK;
    he.hdr.word_count = row.wc;
    he.is_long = long_is_valid(row);
    he.err = (row.dt == `CSI_ERR_DT) ||
             ((row.dt >= `CSI_LONG_MIN_DT) && (row.wc[1:0] != 2'b00));
    want_hdr_q.push_back(he);
    if (long_is_valid(row)) begin
      crc = `CSI_CRC_INIT;
      for (int k = 0; k < int'(row.wc[15:2]); k++) begin
        take_random_bits(32, rnd);
        pw = rnd;
        drive_word(pw, c);
        pe.cyc = c + 2;
        pe.word = pw;
        want_pl_q.push_back(pe);
        for (int b = 0; b < 4; b++) begin
          crc = crc_update_byte(crc, pw.bytes[b]);
        end
      end
      // Upper half of the checksum word is noise the checker must ignore
      take_random_bits(16, rnd);
      ck = row.corrupt ? ~crc : crc;
      pw = {rnd[15:0], ck};
      drive_word(pw, c);
      ce.cyc = c + 3;
      ce.err = row.corrupt;
      want_crc_q.push_back(ce);
    end
  endtask

  task automatic compare_header(input int idx, input hdr_ev_t got, input hdr_ev_t want);
    if (got.cyc != want.cyc) begin
      value_fail($sformatf("header %0d acked at cycle %0d, expected %0d",
                           idx, got.cyc, want.cyc));
    end
    if (got.hdr !== want.hdr) begin
      value_fail($sformatf("header %0d fields %h, expected %h", idx, got.hdr, want.hdr));
    end
    if (got.is_long !== want.is_long || got.err !== want.err) begin
      value_fail($sformatf("header %0d long/error %b%b, expected %b%b",
                           idx, got.is_long, got.err, want.is_long, want.err));
    end
  endtask

  task automatic compare_payload(input int idx, input pl_ev_t got, input pl_ev_t want);
    if (got.cyc != want.cyc || got.word !== want.word) begin
      value_fail($sformatf("payload %0d is %h at cycle %0d, expected %h at cycle %0d",
                           idx, got.word, got.cyc, want.word, want.cyc));
    end
  endtask

  task automatic compare_crc(input int idx, input crc_ev_t got, input crc_ev_t want);
    if (got.cyc != want.cyc || got.err !== want.err) begin
      value_fail($sformatf("checksum %0d error %b at cycle %0d, expected %b at cycle %0d",
                           idx, got.err, got.cyc, want.err, want.cyc));
    end
  endtask

  // Budget of 50 cycles per table word plus a margin for reset and drain
  initial begin : watchdog
    int words;
    words = count_table_words();
    #((words * 50 + 100) * 40);
    $display("Timeout: the run did not finish within %0d cycles", words * 50 + 100);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    packet_data = 32'h0;
    packet_req = 1'b0;
    rst_n = 1'b0;
    lfsr_state = 32'h76d3_bb6f;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();
    for (int r = 0; r < NROWS; r++) begin
      apply_row(rows[r]);
    end
    // Let the last checksum result come out
    repeat (8) drive_idle();
    if (got_hdr_q.size() == want_hdr_q.size() && got_pl_q.size() == want_pl_q.size() &&
        got_crc_q.size() == want_crc_q.size()) begin
      foreach (want_hdr_q[i]) compare_header(i, got_hdr_q[i], want_hdr_q[i]);
      foreach (want_pl_q[i]) compare_payload(i, got_pl_q[i], want_pl_q[i]);
      foreach (want_crc_q[i]) compare_crc(i, got_crc_q[i], want_crc_q[i]);
      $display("sim passed");
      $finish;
    end else begin
      $display("Wrong event counts: headers %0d of %0d, payload %0d of %0d, checksums %0d of %0d",
               got_hdr_q.size(), want_hdr_q.size(), got_pl_q.size(), want_pl_q.size(),
               got_crc_q.size(), want_crc_q.size());
      $display("sim failed");
      $fatal(1, "event counts differ");
    end
  end

endmodule

// File: src/csi_rx_top.sv
// Receiver packet layer top; inputs must already be lane-merged and word-aligned
`timescale 1ns/10ps

module csi_rx_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] packet_data,
  input  logic        packet_req,
  output logic [7:0]  packet_type,
  output logic [7:0]  virtual_channel,
  output logic [15:0] word_count,
  output logic        is_long_packet,
  output logic        decode_error,
  output logic        packet_ack,
  output logic [31:0] payload_data,
  output logic        payload_strobe,
  output logic        crc_strobe,
  output logic        crc_error
);

  // Body words flow from decoder to checker over this bus
  csi_payload_if pl_bus ();

  csi_packet_decoder csi_packet_decoder_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .packet_data     (packet_data),
    .packet_req      (packet_req),
    .packet_type     (packet_type),
    .virtual_channel (virtual_channel),
    .word_count      (word_count),
    .is_long_packet  (is_long_packet),
    .decode_error    (decode_error),
    .packet_ack      (packet_ack),
    .pl              (pl_bus.dec)
  );

  csi_payload_checker csi_payload_checker_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .pl         (pl_bus.chk),
    .crc_strobe (crc_strobe),
    .crc_error  (crc_error)
  );

  // Payload is visible outside only when the strobe is not for a checksum word
  assign payload_data   = pl_bus.word;
  assign payload_strobe = pl_bus.strobe && !pl_bus.is_crc;

endmodule

// File: src/csi_packet_decoder.sv
// Expects aligned words with a one-cycle req and no back-pressure; counts must be multiples of 4
`timescale 1ns/10ps
`include "csi_defs.svh"

module csi_packet_decoder (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] packet_data,
  input  logic        packet_req,
  output logic [7:0]  packet_type,
  output logic [7:0]  virtual_channel,
  output logic [15:0] word_count,
  output logic        is_long_packet,
  output logic        decode_error,
  output logic        packet_ack,
  csi_payload_if.dec  pl
);

  // All decoding works on the input register stage one cycle behind the pins
  csi_pkg::csi_word_u data_r;
  logic               req_r;

  // Payload words still expected for the current long packet
  logic [13:0] remain;
  // The checksum word is still owed after the payload
  logic        crc_pend;
  // Next forwarded word is the first one after its header
  logic        first_pend;

  // A registered strobe that belongs to a packet body rather than a header
  logic fwd;

  assign fwd = req_r && ((remain != 14'd0) || crc_pend);

  // The registered strobe marks a valid word in data_r
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_r <= 1'b0;
    end else begin
      req_r <= packet_req;
    end
  end

  always_ff @(posedge clk) begin
    data_r <= packet_data;
  end

  // Body words are copied straight onto the interface
  always_ff @(posedge clk) begin
    if (fwd) begin
      pl.word <= data_r;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      packet_type     <= 8'h00;
      virtual_channel <= 8'h00;
      word_count      <= 16'h0000;
      is_long_packet  <= 1'b0;
      decode_error    <= 1'b0;
      packet_ack      <= 1'b0;
      remain          <= 14'd0;
      crc_pend        <= 1'b0;
      first_pend      <= 1'b0;
      pl.strobe       <= 1'b0;
      pl.first        <= 1'b0;
      pl.is_crc       <= 1'b0;
    end else begin
      // Strobes are single-cycle pulses unless set below
      packet_ack <= 1'b0;
      pl.strobe  <= 1'b0;
      if (req_r) begin
        if (remain != 14'd0) begin
          // Payload word of a long packet
          pl.strobe  <= 1'b1;
          pl.is_crc  <= 1'b0;
          pl.first   <= first_pend;
          first_pend <= 1'b0;
          remain     <= remain - 14'd1;
        end else if (crc_pend) begin
          // Checksum word that is also the first word when the count is zero
          pl.strobe  <= 1'b1;
          pl.is_crc  <= 1'b1;
          pl.first   <= first_pend;
          first_pend <= 1'b0;
          crc_pend   <= 1'b0;
        end else begin
          // Header word whose fields hold until the next header
          packet_type     <= data_r.hdr.data_type;
          virtual_channel <= data_r.hdr.vc_byte & `CSI_VC_MASK;
          word_count      <= data_r.hdr.word_count;
          packet_ack      <= 1'b1;
          if (data_r.hdr.data_type == `CSI_ERR_DT) begin
            decode_error   <= 1'b1;
            is_long_packet <= 1'b0;
          end else if (data_r.hdr.data_type >= `CSI_LONG_MIN_DT) begin
            if (data_r.hdr.word_count[1:0] != 2'b00) begin
              // A partial last word is not supported and is handled like a short packet
              decode_error   <= 1'b1;
              is_long_packet <= 1'b0;
            end else begin
              decode_error   <= 1'b0;
              is_long_packet <= 1'b1;
              remain         <= data_r.hdr.word_count[15:2];
              crc_pend       <= 1'b1;
              first_pend     <= 1'b1;
            end
          end else begin
            // Nothing follows a short packet
            decode_error   <= 1'b0;
            is_long_packet <= 1'b0;
          end
        end
      end
    end
  end

endmodule

// File: payload/csi_payload_checker.sv
// Checks one long packet at a time; the checksum is taken from the low 16 bits of its word
`timescale 1ns/10ps
`include "csi_defs.svh"

module csi_payload_checker (
  input  logic       clk,
  input  logic       rst_n,
  csi_payload_if.chk pl,
  output logic       crc_strobe,
  output logic       crc_error
);

  // Running CRC across the payload words seen so far
  logic [15:0] crc_r;
  // Start value for this word, reseeded at the start of a packet
  logic [15:0] crc_seed;
  // CRC after folding in the current word
  logic [15:0] crc_next;

  // A first word means a new packet, so the old running value is dropped
  assign crc_seed = pl.first ? `CSI_CRC_INIT : crc_r;

  csi_crc16 crc16_inst (
    .crc_in  (crc_seed),
    .word    (pl.word),
    .crc_out (crc_next)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      crc_r      <= `CSI_CRC_INIT;
      crc_strobe <= 1'b0;
      crc_error  <= 1'b0;
    end else begin
      crc_strobe <= 1'b0;
      crc_error  <= 1'b0;
      if (pl.strobe) begin
        if (pl.is_crc) begin
          // Result is valid only together with crc_strobe
          // A zero-length packet compares against the seed itself
          crc_strobe <= 1'b1;
          crc_error  <= ({pl.word.bytes[1], pl.word.bytes[0]} != crc_seed);
        end else begin
          crc_r <= crc_next;
        end
      end
    end
  end

endmodule

// File: payload/csi_crc16.sv
// Pure combinational CRC step over one word; no final XOR, reflected form, byte 0 first
`timescale 1ns/10ps
`include "csi_defs.svh"

module csi_crc16 (
  input  logic [15:0]        crc_in,
  input  csi_pkg::csi_word_u word,
  output logic [15:0]        crc_out
);

  // Walks 32 data bits through the shift register in one cycle
  always_comb begin
    logic [15:0] c;
    logic        fb;
    c = crc_in;
    for (int b = 0; b < 4; b++) begin
      // Each byte enters LSB first, as on the wire
      for (int i = 0; i < 8; i++) begin
        fb = c[0] ^ word.bytes[b][i];
        c  = c >> 1;
        if (fb) begin
          c = c ^ `CSI_CRC_POLY;
        end
      end
    end
    crc_out = c;
  end

endmodule

// File: common/csi_payload_if.sv
// Decoder to checker path; no acknowledge or stall, a strobe may arrive every cycle
`timescale 1ns/10ps

interface csi_payload_if;

  // Forwarded payload or checksum word
  csi_pkg::csi_word_u word;
  // One cycle per forwarded word
  logic strobe;
  // Set on the first word after a header, payload or checksum alike
  logic first;
  // Set when the word carries the checksum in its low half
  logic is_crc;

  // Decoder side
  modport dec (
    output word, strobe, first, is_crc
  );

  // Checker side
  modport chk (
    input word, strobe, first, is_crc
  );

endinterface

// File: common/csi_pkg.sv
// Shared word types; byte 0 is the least significant byte and no ECC byte is modeled
package csi_pkg;

  // Packet header as it sits in one 32-bit word
  // Fields are listed from the MSB down, so data_type lands in byte 0
  typedef struct packed {
    // Payload length in bytes for long packets
    logic [15:0] word_count;
    // Raw byte 1, the decoder masks it down to the channel bits
    logic [7:0]  vc_byte;
    // Byte 0 selects short, long or error handling
    logic [7:0]  data_type;
  } csi_header_t;

  // The same word is either a header or four payload bytes
  // Which view applies depends on where the word falls in the packet
  typedef union packed {
    // Header view, valid only for the first word of a packet
    csi_header_t hdr;
    // Byte view used for payload and checksum words, bytes[0] in the LSBs
    logic [3:0][7:0] bytes;
  } csi_word_u;

endpackage

// File: common/csi_defs.svh
// Protocol constants shared by RTL and testbench; changing them breaks compatibility with the sender
`ifndef CSI_DEFS_SVH
`define CSI_DEFS_SVH

// Only the low two bits of byte 1 carry the virtual channel
`define CSI_VC_MASK 8'h03

// Data types from this value upward announce a long packet with payload
`define CSI_LONG_MIN_DT 8'h10

// Data type zero is reserved and always decodes as an error
`define CSI_ERR_DT 8'h00

// The CRC-16 polynomial in reflected form for data processed LSB first
`define CSI_CRC_POLY 16'h8408

// Seed loaded at the start of every long packet
`define CSI_CRC_INIT 16'hFFFF

`endif
